// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_calc_top
LINT_TOP  = calc_top
FILELIST  = files.f
PASS_MSG  = SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== design/calc_bypass.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand forwarding from completion pipe next-state entries.
// Purely combinational; x0 is never matched.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module calc_bypass
  import calc_pkg::*;
#(
  parameter int data_width_p = 64
)
(
  input  reg_addr_t                                rs1_addr_i,
  input  reg_addr_t                                rs2_addr_i,
  input  logic [data_width_p-1:0]                  rs1_data_i,
  input  logic [data_width_p-1:0]                  rs2_data_i,
  input  logic [calc_stages_lp-1:0]                fwd_v_i,
  input  reg_addr_t [calc_stages_lp-1:0]           fwd_rd_addr_i,
  input  logic [calc_stages_lp-1:0][data_width_p-1:0] fwd_data_i,
  output logic [data_width_p-1:0]                  rs1_o,
  output logic [data_width_p-1:0]                  rs2_o
);

  always_comb
  begin
    rs1_o = rs1_data_i;
    rs2_o = rs2_data_i;
    // Walk oldest to youngest so stage 0 wins
    for (int i = calc_stages_lp-1; i >= 0; i--)
    begin
      if (fwd_v_i[i] && (rs1_addr_i != '0) && (fwd_rd_addr_i[i] == rs1_addr_i))
        rs1_o = fwd_data_i[i];
      if (fwd_v_i[i] && (rs2_addr_i != '0) && (fwd_rd_addr_i[i] == rs2_addr_i))
        rs2_o = fwd_data_i[i];
    end
  end

  // Control must never offer an x0 result for forwarding
  always_comb
  begin
    for (int i = 0; i < calc_stages_lp; i++)
    begin
      assert (!(fwd_v_i[i] && (fwd_rd_addr_i[i] == '0)))
        else $error("bypass: stage %0d forwards to x0", i);
    end
  end

endmodule

`default_nettype wire

// ==== design/calc_comp_pipe.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completion data shift register, one stage per edge.
// Pipes mux their results in at fixed stages; single issue
// with static latencies keeps them from colliding.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module calc_comp_pipe
  import calc_pkg::*;
#(
  parameter int data_width_p = 64
)
(
  input  logic                                     clk_i,
  input  logic                                     int_sel_i,
  input  logic [data_width_p-1:0]                  int_data_i,
  input  logic                                     mul_sel_i,
  input  logic [data_width_p-1:0]                  mul_data_i,
  output logic [calc_stages_lp-1:0][data_width_p-1:0] stage_n_o,
  output logic [data_width_p-1:0]                  wb_data_o
);

  logic [calc_stages_lp-1:0][data_width_p-1:0] stage_r;
  logic [calc_stages_lp-1:0][data_width_p-1:0] shift_in;

  // Each stage sees the one before it, stage 0 sees zero
  assign shift_in = {stage_r[calc_stages_lp-2:0], {data_width_p{1'b0}}};

  always_comb
  begin
    for (int i = 0; i < calc_stages_lp; i++)
    begin
      if ((i == int_stage_lp) && int_sel_i)
        stage_n_o[i] = int_data_i;
      else if ((i == mul_stage_lp) && mul_sel_i)
        stage_n_o[i] = mul_data_i;
      else
        stage_n_o[i] = shift_in[i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= stage_n_o;
  end

  // Last stage feeds the register writeback port
  assign wb_data_o = stage_r[calc_stages_lp-1];

endmodule

`default_nettype wire

// ==== design/calc_pipe_int.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle integer ALU on the reservation operands.
// Shift amount is the low log2(width) bits of rs2.
// Multiply opcode yields zero here; the multiply pipe owns it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module calc_pipe_int
  import calc_pkg::*;
#(
  parameter int data_width_p = 64
)
(
  input  calc_op_e                op_i,
  input  logic [data_width_p-1:0] rs1_i,
  input  logic [data_width_p-1:0] rs2_i,
  output logic [data_width_p-1:0] data_o
);

  localparam int shamt_width_lp = $clog2(data_width_p);

  logic [shamt_width_lp-1:0] shamt;
  logic                      lt;

  assign shamt = rs2_i[shamt_width_lp-1:0];

  // Signed compare for slt
  assign lt = $signed(rs1_i) < $signed(rs2_i);

  always_comb
  begin
    case (op_i)
      e_calc_add:
        data_o = rs1_i + rs2_i;
      e_calc_sub:
        data_o = rs1_i - rs2_i;
      e_calc_and:
        data_o = rs1_i & rs2_i;
      e_calc_or:
        data_o = rs1_i | rs2_i;
      e_calc_xor:
        data_o = rs1_i ^ rs2_i;
      e_calc_sll:
        data_o = rs1_i << shamt;
      e_calc_slt:
        data_o = {{(data_width_p-1){1'b0}}, lt};
      default:
        data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/calc_pipe_mul.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-register multiply, low word only, no valid tracking.
// Product is meaningful two edges after the operands are
// taken; control decides when to use it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module calc_pipe_mul
#(
  parameter int data_width_p = 64
)
(
  input  logic                    clk_i,
  input  logic [data_width_p-1:0] rs1_i,
  input  logic [data_width_p-1:0] rs2_i,
  output logic [data_width_p-1:0] data_o
);

  logic [data_width_p-1:0] rs1_r;
  logic [data_width_p-1:0] rs2_r;
  logic [data_width_p-1:0] prod_lo;

  // Low word of the product, upper half is dropped
  assign prod_lo = rs1_r * rs2_r;

  always_ff @(posedge clk_i)
  begin
    rs1_r  <= rs1_i;
    rs2_r  <= rs2_i;
    data_o <= prod_lo;
  end

endmodule

`default_nettype wire

// ==== design/calc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and pipe depths for the calculator backend.
// Only integer ALU ops and a low-word multiply exist.
// Stage indices count completion stages from 0.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package calc_pkg;

  // Operation codes as seen at dispatch
  typedef enum logic [2:0]
  {
    e_calc_add = 3'd0,
    e_calc_sub = 3'd1,
    e_calc_and = 3'd2,
    e_calc_or  = 3'd3,
    e_calc_xor = 3'd4,
    e_calc_sll = 3'd5,
    e_calc_slt = 3'd6,
    e_calc_mul = 3'd7
  } calc_op_e;

  // Architectural register index, x0 reads as zero
  typedef logic [4:0] reg_addr_t;

  // Completion pipe depth
  localparam int calc_stages_lp = 4;

  // Stage where each pipe drops its result
  localparam int int_stage_lp = 0;
  localparam int mul_stage_lp = 2;

endpackage

`default_nettype wire

// ==== design/calc_stage_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reservation control and per-stage valid/poison/rd tracking.
// Writes to x0 never enter as valid. Flush poisons every
// stage that has not yet reached writeback.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module calc_stage_ctrl
  import calc_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           dispatch_v_i,
  input  calc_op_e                       op_i,
  input  reg_addr_t                      rd_addr_i,
  input  logic                           flush_i,
  output calc_op_e                       res_op_o,
  output logic                           int_sel_o,
  output logic                           mul_sel_o,
  output logic [calc_stages_lp-1:0]      fwd_v_o,
  output reg_addr_t [calc_stages_lp-1:0] fwd_rd_addr_o,
  output logic                           wb_v_o,
  output reg_addr_t                      wb_rd_addr_o
);

  logic      res_v_r;
  logic      res_poison_r;
  reg_addr_t res_rd_r;

  logic [calc_stages_lp-1:0]      stage_v_r, stage_poison_r;
  // Last stage needs no multiply flag
  logic [calc_stages_lp-2:0]      stage_mul_r;
  logic [calc_stages_lp-1:0]      stage_v_n, stage_poison_n, stage_mul_n;
  reg_addr_t [calc_stages_lp-1:0] stage_rd_r, stage_rd_n;

  always_comb
  begin
    // Reservation enters stage 0
    stage_v_n[0]      = res_v_r & (res_rd_r != '0);
    stage_poison_n[0] = res_poison_r | flush_i;
    stage_mul_n[0]    = (res_op_o == e_calc_mul);
    stage_rd_n[0]     = res_rd_r;
    for (int i = 1; i < calc_stages_lp; i++)
    begin
      stage_v_n[i]      = stage_v_r[i-1];
      stage_poison_n[i] = stage_poison_r[i-1] | flush_i;
      stage_mul_n[i]    = stage_mul_r[i-1];
      stage_rd_n[i]     = stage_rd_r[i-1];
    end
    // Only finished, live results are offered to the bypass
    for (int i = 0; i < calc_stages_lp; i++)
    begin
      fwd_v_o[i] = stage_v_n[i] & ~stage_poison_n[i]
                   & (stage_mul_n[i] ? (i >= mul_stage_lp) : (i >= int_stage_lp));
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      res_v_r        <= 1'b0;
      res_poison_r   <= 1'b0;
      stage_v_r      <= '0;
      stage_poison_r <= '0;
      stage_mul_r    <= '0;
    end
    else
    begin
      res_v_r        <= dispatch_v_i;
      res_poison_r   <= flush_i;
      stage_v_r      <= stage_v_n;
      stage_poison_r <= stage_poison_n;
      stage_mul_r    <= stage_mul_n[calc_stages_lp-2:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    res_op_o   <= op_i;
    res_rd_r   <= rd_addr_i;
    stage_rd_r <= stage_rd_n;
  end

  assign int_sel_o     = res_v_r & (res_op_o != e_calc_mul);
  assign mul_sel_o     = stage_v_r[1] & stage_mul_r[1];
  assign fwd_rd_addr_o = stage_rd_n;

  assign wb_v_o       = stage_v_r[calc_stages_lp-1] & ~stage_poison_r[calc_stages_lp-1];
  assign wb_rd_addr_o = stage_rd_r[calc_stages_lp-1];

  // An integer op must not be claimed by the multiply mux two stages on
  assert property (@(posedge clk_i) disable iff (!arst_n_i) int_sel_o |-> ##2 !mul_sel_o);

  // x0 filter at stage entry must hold all the way to writeback
  assert property (@(posedge clk_i) disable iff (!arst_n_i) wb_v_o |-> (wb_rd_addr_o != '0));

endmodule

`default_nettype wire

// ==== design/calc_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Calculator backend top: one dispatch per cycle, fixed
// 4-cycle writeback latency. The issuer must space multiply
// consumers at least three cycles after the multiply.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module calc_top
  import calc_pkg::*;
#(
  parameter int data_width_p = 64
)
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    dispatch_v_i,
  input  calc_op_e                op_i,
  input  reg_addr_t               rd_addr_i,
  input  reg_addr_t               rs1_addr_i,
  input  reg_addr_t               rs2_addr_i,
  input  logic [data_width_p-1:0] rs1_data_i,
  input  logic [data_width_p-1:0] rs2_data_i,
  input  logic                    flush_i,
  output logic                    wb_v_o,
  output reg_addr_t               wb_rd_addr_o,
  output logic [data_width_p-1:0] wb_data_o
);

  calc_op_e                                    res_op;
  logic                                        int_sel, mul_sel;
  logic [calc_stages_lp-1:0]                   fwd_v;
  reg_addr_t [calc_stages_lp-1:0]              fwd_rd_addr;
  logic [calc_stages_lp-1:0][data_width_p-1:0] comp_stage_n;
  logic [data_width_p-1:0]                     bypass_rs1, bypass_rs2;
  logic [data_width_p-1:0]                     res_rs1_r, res_rs2_r;
  logic [data_width_p-1:0]                     int_data, mul_data;

  calc_stage_ctrl ctrl0
  (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .dispatch_v_i(dispatch_v_i), .op_i(op_i),
    .rd_addr_i(rd_addr_i), .flush_i(flush_i), .res_op_o(res_op), .int_sel_o(int_sel),
    .mul_sel_o(mul_sel), .fwd_v_o(fwd_v), .fwd_rd_addr_o(fwd_rd_addr),
    .wb_v_o(wb_v_o), .wb_rd_addr_o(wb_rd_addr_o)
  );

  calc_bypass #(.data_width_p(data_width_p)) bypass0
  (
    .rs1_addr_i(rs1_addr_i), .rs2_addr_i(rs2_addr_i), .rs1_data_i(rs1_data_i),
    .rs2_data_i(rs2_data_i), .fwd_v_i(fwd_v), .fwd_rd_addr_i(fwd_rd_addr),
    .fwd_data_i(comp_stage_n), .rs1_o(bypass_rs1), .rs2_o(bypass_rs2)
  );

  // Reservation operands, already bypassed
  always_ff @(posedge clk_i)
  begin
    res_rs1_r <= bypass_rs1;
    res_rs2_r <= bypass_rs2;
  end

  calc_pipe_int #(.data_width_p(data_width_p)) pipe_int0
  (
    .op_i(res_op), .rs1_i(res_rs1_r), .rs2_i(res_rs2_r), .data_o(int_data)
  );

  calc_pipe_mul #(.data_width_p(data_width_p)) pipe_mul0
  (
    .clk_i(clk_i), .rs1_i(res_rs1_r), .rs2_i(res_rs2_r), .data_o(mul_data)
  );

  calc_comp_pipe #(.data_width_p(data_width_p)) comp0
  (
    .clk_i(clk_i), .int_sel_i(int_sel), .int_data_i(int_data), .mul_sel_i(mul_sel),
    .mul_data_i(mul_data), .stage_n_o(comp_stage_n), .wb_data_o(wb_data_o)
  );

endmodule

`default_nettype wire

// ==== files.f ====
design/calc_pkg.sv
design/calc_bypass.sv
design/calc_pipe_int.sv
design/calc_pipe_mul.sv
design/calc_comp_pipe.sv
design/calc_stage_ctrl.sv
design/calc_top.sv
tests/tb_calc_top.sv

// ==== tests/calc_golden.txt ====
// Cols: dispatch_v flush op rd rs1_addr rs2_addr rs1_data rs2_data, exp wb_v wb_rd wb_data
// One cycle per line, all hex; expected columns are the outputs after this line's edge
1 0 0 0a 01 02 c                5                0 00 0  // alu ops
1 0 1 0b 01 02 c                5                0 00 0
1 0 2 0c 05 01 ff               c                0 00 0
1 0 3 0d 01 02 c                5                0 00 0
1 0 4 0e 05 01 ff               c                1 0a 11
1 0 5 0f 01 04 c                3                1 0b 7
1 0 6 10 03 02 fffffffffffffffd 5                1 0c c
1 0 0 11 02 02 5                5                1 0d d  // int forwarding
1 0 1 12 11 04 0                3                1 0e f3
1 0 3 13 02 12 5                0                1 0f 60
1 0 0 14 11 13 0                0                1 10 1
1 0 4 14 14 12 0                0                1 11 a
1 0 0 15 14 02 0                5                1 12 7
1 0 7 16 03 02 fffffffffffffffd 5                1 13 7  // mul forwarding
0 0 0 00 00 00 0                0                1 14 11
0 0 0 00 00 00 0                0                1 14 16
1 0 0 17 16 05 0                ff               1 15 1b
1 0 1 18 16 01 0                c                1 16 fffffffffffffff1
1 0 0 00 01 02 c                5                0 00 0  // x0 writes
1 0 3 19 00 02 0                5                0 00 0
1 0 0 1a 01 01 c                c                1 17 f0  // flush
1 0 7 1b 01 01 c                c                1 18 ffffffffffffffe5
1 0 0 1c 1a 02 0                5                0 00 0
1 0 0 1d 01 02 c                5                1 19 5
1 1 2 1e 05 01 ff               c                0 00 0
1 0 0 0b 1c 1e 40               200              0 00 0
1 0 7 08 02 06 5                7                0 00 0  // int/mul alternating
1 0 0 09 01 06 c                7                0 00 0
1 0 7 1f 05 04 ff               3                0 00 0
1 0 1 07 05 06 ff               7                1 0b 240
0 0 0 00 00 00 0                0                1 08 23
0 0 0 00 00 00 0                0                1 09 13
0 0 0 00 00 00 0                0                1 1f 2fd
0 0 0 00 00 00 0                0                1 07 f8

// ==== tests/tb_calc_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replays tests/calc_golden.txt against calc_top at 64 bits,
// one line per cycle. Must be run from the project root.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module tb_calc_top
  import calc_pkg::*;
();

  localparam int data_width_lp = 64;
  localparam int fields_lp     = 11;
  localparam int lines_lp      = 34;
  localparam int tests_lp      = 6;

  // Last golden line of each test group
  localparam int group_last_lp [tests_lp] = '{6, 12, 17, 19, 25, 33};

  logic                     clk;
  logic                     arst_n;
  logic                     dispatch_v;
  logic                     flush;
  calc_op_e                 op;
  reg_addr_t                rd_addr;
  reg_addr_t                rs1_addr;
  reg_addr_t                rs2_addr;
  logic [data_width_lp-1:0] rs1_data;
  logic [data_width_lp-1:0] rs2_data;
  logic                     wb_v;
  reg_addr_t                wb_rd_addr;
  logic [data_width_lp-1:0] wb_data;

  logic [63:0] golden [lines_lp*fields_lp];
  string       group_name [tests_lp] = '{"alu ops", "int forwarding", "mul forwarding",
                                         "x0 writes", "flush", "int/mul alternating"};
  int          group_errors;
  int          tests_passed;
  int          tests_failed;
  int          test_idx;
  int unsigned seed;
  bit          ran_out;

  calc_top #(.data_width_p(data_width_lp)) dut0
  (
    .clk_i(clk), .arst_n_i(arst_n), .dispatch_v_i(dispatch_v), .op_i(op),
    .rd_addr_i(rd_addr), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .flush_i(flush),
    .wb_v_o(wb_v), .wb_rd_addr_o(wb_rd_addr), .wb_data_o(wb_data)
  );

  always #4 clk = ~clk;

  task automatic check_v(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Fail %0t %s: got %b, expected %b", $time, name, got, exp);
      group_errors++;
    end
  endtask

  task automatic check_rd(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
    begin
      $display("Fail %0t %s: got %0d, expected %0d", $time, name, got, exp);
      group_errors++;
    end
  endtask

  task automatic check_data(input string name, input logic [data_width_lp-1:0] got,
                            input logic [data_width_lp-1:0] exp);
    if (got !== exp)
    begin
      $display("Fail %0t %s: got %h, expected %h", $time, name, got, exp);
      group_errors++;
    end
  endtask

  task automatic drive_line(input int n);
    int b;
    b          = n * fields_lp;
    dispatch_v = golden[b][0];
    flush      = golden[b+1][0];
    op         = calc_op_e'(golden[b+2][2:0]);
    rd_addr    = golden[b+3][4:0];
    rs1_addr   = golden[b+4][4:0];
    rs2_addr   = golden[b+5][4:0];
    rs1_data   = golden[b+6];
    rs2_data   = golden[b+7];
  endtask

  task automatic score_line(input int n);
    int b;
    b = n * fields_lp;
    check_v("wb_v_o", wb_v, golden[b+8][0]);
    // rd and data only mean something with a writeback
    if (golden[b+8][0])
    begin
      check_rd("wb_rd_addr_o", wb_rd_addr, golden[b+9][4:0]);
      check_data("wb_data_o", wb_data, golden[b+10]);
    end
  endtask

  task automatic close_test();
    if (group_errors == 0)
    begin
      $display("test %0d %s: pass", test_idx + 1, group_name[test_idx]);
      tests_passed++;
    end
    else
    begin
      $display("test %0d %s: fail, %0d mismatches", test_idx + 1, group_name[test_idx],
               group_errors);
      tests_failed++;
    end
    group_errors = 0;
    test_idx++;
  endtask

  initial
  begin
    seed         = 32'ha120;
    clk          = 1'b0;
    arst_n       = 1'b0;
    dispatch_v   = 1'b0;
    flush        = 1'b0;
    op           = e_calc_add;
    rd_addr      = '0;
    rs1_addr     = '0;
    rs2_addr     = '0;
    rs1_data     = '0;
    rs2_data     = '0;
    group_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_idx     = 0;
    ran_out      = 1'b0;
    $readmemh("tests/calc_golden.txt", golden);
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // Outputs are registered, so the next falling edge sees this line's result
    for (int n = 0; (n < lines_lp) && !ran_out; n++)
    begin
      if ($isunknown(golden[n*fields_lp + fields_lp - 1]))
      begin
        $display("golden file ran out at line %0d", n);
        ran_out = 1'b1;
      end
      else
      begin
        drive_line(n);
        @(negedge clk);
        score_line(n);
        if (n == group_last_lp[test_idx])
          close_test();
      end
    end
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if ((tests_failed == 0) && !ran_out)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // The replay takes about 40 cycles
  initial
  begin
    for (int c = 0; c < 200; c++)
      @(posedge clk);
    $display("timeout: replay did not finish within 200 cycles");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
